// ==== Bender.yml ====
package:
  name: noc_router

sources:
  - files:
      - src/noc_router_pkg.sv
      - src/router_ifs.sv
      - src/flit_fifo.sv
      - src/input_unit.sv
      - src/output_arbiter.sv
      - src/switch_fabric.sv
      - src/noc_router.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/router_tb.sv

// ==== src/flit_fifo.sv ====
// Small synchronous FIFO used for the flit and destination buffers.
// The payload type is a parameter. rdata is loaded on rd and then holds
// its value, so it doubles as the head register of an input.
// Overflow is prevented by the credit protocol, so there is no full flag.

`timescale 1ns/100ps

module flit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr,
    input  payload_t wdata,
    input  logic     rd,
    output logic     empty,
    output payload_t rdata
);
    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] count_t;

    payload_t mem [DEPTH];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    count_t   count;

    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wdata;
        end
        if (rd) begin
            rdata <= mem[rd_ptr];
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + count_t'(wr) - count_t'(rd);
        end
    end

endmodule

// ==== src/input_unit.sv ====
// One router input. Buffers incoming flits and, per packet, the
// destination. Presents the head flit with its one-hot route request
// to the switch fabric and returns a credit for every flit it reads
// out of the buffer.

`timescale 1ns/100ps

module input_unit import noc_router_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  flit_t data,
    input  dest_t dest,
    input  logic  send,
    output logic  credit,
    flit_link_if.unit link
);
    flit_t head_flit;
    dest_t head_dest;
    logic  flit_empty;
    logic  dest_empty;
    logic  flit_rd;
    logic  dest_rd;
    logic  head_valid;
    logic  receiving;
    logic  transiting;
    logic  new_packet;

    flit_fifo #(
        .payload_t (flit_t),
        .DEPTH     (BUFFER_DEPTH)
    ) u_flit_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (send),
        .wdata (data),
        .rd    (flit_rd),
        .empty (flit_empty),
        .rdata (head_flit)
    );

    // Only the first flit of a packet carries a valid destination
    flit_fifo #(
        .payload_t (dest_t),
        .DEPTH     (BUFFER_DEPTH)
    ) u_dest_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (send & ~receiving),
        .wdata (dest),
        .rd    (dest_rd),
        .empty (dest_empty),
        .rdata (head_dest)
    );

    // Refill the head whenever it is empty or leaving this cycle
    assign flit_rd    = ~flit_empty & (~head_valid | link.accept);
    assign credit     = flit_rd;

    // A new packet starts unless the current head is mid-packet
    assign new_packet = ~(transiting & ~head_flit.is_tail);
    assign dest_rd    = flit_rd & new_packet & ~dest_empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            receiving  <= 1'b0;
            transiting <= 1'b0;
            head_valid <= 1'b0;
        end else begin
            if (send) begin
                receiving <= ~data.is_tail;
            end
            if (head_valid) begin
                transiting <= ~head_flit.is_tail;
            end
            if (flit_rd) begin
                transiting <= 1'b1;
            end
            if (flit_rd) begin
                head_valid <= 1'b1;
            end else if (link.accept) begin
                head_valid <= 1'b0;
            end
        end
    end

    assign link.head    = head_flit;
    assign link.dest    = head_dest;
    assign link.valid   = head_valid;
    assign link.request = head_valid ? (port_vec_t'(1) << ROUTE_TABLE[head_dest]) : '0;

endmodule

// ==== src/noc_router.sv ====
// Top level of the NUM_PORTS x NUM_PORTS credit-flow wormhole router.
// Upstream senders may raise send_in only while holding a credit; each
// credit_out pulse returns one slot. Downstream receivers pulse credit_in
// for every slot they free. dest_in is sampled on a packet's first flit.

`timescale 1ns/100ps

module noc_router import noc_router_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic [FLIT_WIDTH-1:0] data_in     [NUM_PORTS],
    input  dest_t                 dest_in     [NUM_PORTS],
    input  logic                  is_tail_in  [NUM_PORTS],
    input  logic                  send_in     [NUM_PORTS],
    output logic                  credit_out  [NUM_PORTS],

    output logic [FLIT_WIDTH-1:0] data_out    [NUM_PORTS],
    output dest_t                 dest_out    [NUM_PORTS],
    output logic                  is_tail_out [NUM_PORTS],
    output logic                  send_out    [NUM_PORTS],
    input  logic                  credit_in   [NUM_PORTS]
);
    flit_link_if links [NUM_PORTS] ();

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_input
        input_unit u_input_unit (
            .clk    (clk),
            .rst_n  (rst_n),
            .data   (flit_t'{data_in[i], is_tail_in[i]}),
            .dest   (dest_in[i]),
            .send   (send_in[i]),
            .credit (credit_out[i]),
            .link   (links[i])
        );
    end

    switch_fabric u_switch_fabric (
        .clk         (clk),
        .rst_n       (rst_n),
        .credit_in   (credit_in),
        .data_out    (data_out),
        .dest_out    (dest_out),
        .is_tail_out (is_tail_out),
        .send_out    (send_out),
        .links       (links)
    );

endmodule

// ==== src/noc_router_pkg.sv ====
// Shared constants and types for the credit-flow wormhole router.
// Every RTL file and the testbench import this package for the port
// count, flit layout and the fixed destination-to-output routing table.

package noc_router_pkg;

    // Router geometry
    localparam int NUM_PORTS    = 5;
    localparam int FLIT_WIDTH   = 32;
    localparam int DEST_WIDTH   = 3;

    // Per-input buffer slots, also the starting credit of every sender
    localparam int BUFFER_DEPTH = 2;

    localparam int PORT_W       = $clog2(NUM_PORTS);
    localparam int CREDIT_W     = $clog2(BUFFER_DEPTH + 1);

    // One flit as it travels through the buffers and the crossbar
    typedef struct packed {
        logic [FLIT_WIDTH-1:0] data;
        logic                  is_tail;
    } flit_t;

    typedef logic [DEST_WIDTH-1:0] dest_t;

    // One bit per port, used for one-hot selects and request masks
    typedef logic [NUM_PORTS-1:0] port_vec_t;

    // Output index for each destination
    localparam logic [PORT_W-1:0] ROUTE_TABLE [2**DEST_WIDTH] = '{
        3'd2,
        3'd0,
        3'd4,
        3'd1,
        3'd3,
        3'd0,
        3'd1,
        3'd2
    };

endpackage

// ==== src/output_arbiter.sv ====
// Arbiter and credit counter for one router output.
// A matrix arbiter picks the least recently granted requester and then
// stays on that input until its tail flit has been sent. A flit is sent
// only while the downstream buffer has a free slot.

`timescale 1ns/100ps

module output_arbiter import noc_router_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic credit,
    arbiter_port_if.arbiter port
);
    // prio[i][j] set means input i wins over input j
    logic [NUM_PORTS-1:0] prio [NUM_PORTS];
    port_vec_t            deactivate;
    port_vec_t            grant_new;
    port_vec_t            hold;
    port_vec_t            hold_q;
    port_vec_t            grant_q;
    port_vec_t            locked_grant;
    logic [CREDIT_W-1:0]  credit_cnt;

    // A requester loses if any higher-priority input also requests
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            deactivate[i] = 1'b0;
            for (int j = 0; j < NUM_PORTS; j++) begin
                deactivate[i] = deactivate[i] | (prio[j][i] & port.request[j]);
            end
        end
    end

    assign grant_new    = port.request & ~deactivate;

    // Grant from last cycle that is still inside its packet
    assign locked_grant = hold_q & grant_q;
    assign port.grant   = (locked_grant != '0) ? locked_grant : grant_new;

    assign port.send    = ((port.grant & port.request) != '0) && (credit_cnt != '0);

    // Lock drops once the tail has gone out
    assign hold = ~(port.head_tail & {NUM_PORTS{port.send}});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= '0;
            grant_q <= '0;
            // Lower index starts with higher priority
            for (int i = 0; i < NUM_PORTS; i++) begin
                for (int j = 0; j < NUM_PORTS; j++) begin
                    prio[i][j] <= (i < j);
                end
            end
        end else begin
            hold_q  <= hold;
            grant_q <= port.grant;
            // Winner moves below every other input
            for (int i = 0; i < NUM_PORTS; i++) begin
                for (int j = 0; j < NUM_PORTS; j++) begin
                    if (i != j) begin
                        prio[i][j] <= (prio[i][j] & ~port.grant[i]) | port.grant[j];
                    end
                end
            end
        end
    end

    // Free slots in the next router's input buffer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= CREDIT_W'(BUFFER_DEPTH);
        end else begin
            credit_cnt <= credit_cnt + CREDIT_W'(credit) - CREDIT_W'(port.send);
        end
    end

endmodule

// ==== src/router_ifs.sv ====
// Internal interfaces of the router.
// flit_link_if carries one input's head flit and route request to the
// switch fabric, and the accept strobe back. arbiter_port_if connects the
// fabric to one output arbiter.

`timescale 1ns/100ps

interface flit_link_if import noc_router_pkg::*; ();

    flit_t     head;
    dest_t     dest;
    logic      valid;
    port_vec_t request;
    // Head flit left the input this cycle
    logic      accept;

    modport unit   (output head, dest, valid, request, input accept);
    modport fabric (input head, dest, valid, request, output accept);

endinterface

interface arbiter_port_if import noc_router_pkg::*; ();

    // Inputs that want this output
    port_vec_t request;
    // Requesting inputs whose head flit is a tail
    port_vec_t head_tail;
    port_vec_t grant;
    logic      send;

    modport fabric  (output request, head_tail, input grant, send);
    modport arbiter (input request, head_tail, output grant, send);

endinterface

// ==== src/switch_fabric.sv ====
// Switch allocation and crossbar of the router.
// Turns per-input route requests into per-output request masks, runs one
// arbiter per output, moves granted head flits through a one-hot
// crossbar and tells each input when its head flit has left.

`timescale 1ns/100ps

module switch_fabric import noc_router_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  credit_in   [NUM_PORTS],
    output logic [FLIT_WIDTH-1:0] data_out    [NUM_PORTS],
    output dest_t                 dest_out    [NUM_PORTS],
    output logic                  is_tail_out [NUM_PORTS],
    output logic                  send_out    [NUM_PORTS],
    flit_link_if.fabric           links       [NUM_PORTS]
);
    flit_t     head        [NUM_PORTS];
    dest_t     head_dest   [NUM_PORTS];
    port_vec_t in_request  [NUM_PORTS];
    port_vec_t out_request [NUM_PORTS];
    port_vec_t out_tail    [NUM_PORTS];
    port_vec_t grant       [NUM_PORTS];
    port_vec_t head_valid;
    port_vec_t send;
    port_vec_t accept;

    arbiter_port_if arb [NUM_PORTS] ();

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_link
        assign head[i]          = links[i].head;
        assign head_dest[i]     = links[i].dest;
        assign head_valid[i]    = links[i].valid;
        assign in_request[i]    = links[i].request;
        assign links[i].accept  = accept[i];
    end

    // Transpose input-major requests into output-major masks
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                out_request[o][i] = head_valid[i] & in_request[i][o];
                out_tail[o][i]    = out_request[o][i] & head[i].is_tail;
            end
        end
    end

    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_output
        assign arb[o].request   = out_request[o];
        assign arb[o].head_tail = out_tail[o];
        assign grant[o]         = arb[o].grant;
        assign send[o]          = arb[o].send;

        output_arbiter u_output_arbiter (
            .clk    (clk),
            .rst_n  (rst_n),
            .credit (credit_in[o]),
            .port   (arb[o])
        );
    end

    // One-hot crossbar and accept feedback
    always_comb begin
        accept = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            data_out[o]    = '0;
            dest_out[o]    = '0;
            is_tail_out[o] = 1'b0;
            send_out[o]    = send[o];
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (grant[o][i]) begin
                    data_out[o]    = data_out[o] | head[i].data;
                    dest_out[o]    = dest_out[o] | head_dest[i];
                    is_tail_out[o] = is_tail_out[o] | head[i].is_tail;
                end
                accept[i] = accept[i] | (grant[o][i] & send[o]);
            end
        end
    end

endmodule

// ==== tb.f ====
+incdir+tests
src/noc_router_pkg.sv
src/router_ifs.sv
src/flit_fifo.sv
src/input_unit.sv
src/output_arbiter.sv
src/switch_fabric.sv
src/noc_router.sv
tests/router_tb.sv

// ==== tests/router_cases.svh ====
// Stimulus table for the router testbench, included inside router_tb.
// Each test waits an idle gap, then queues its packets on their inputs at once.
// Each packet row also gives the output that the routing rule expects for its destination.

`ifndef ROUTER_CASES_SVH
`define ROUTER_CASES_SVH

localparam int NUM_TESTS   = 5;
localparam int NUM_PKTS    = 18;
localparam int HOLD_CYCLES = 40;

// Idle gap before start, packets must leave in table order, check latency
localparam int TEST_TABLE [NUM_TESTS][3] = '{
    '{2, 1, 0},
    '{8, 0, 1},
    '{4, 0, 0},
    '{4, 0, 0},
    '{4, 0, 0}
};

// Test, input, destination, length (0 means random 1 to 4), sink withholds, expected output
localparam int PKT_TABLE [NUM_PKTS][6] = '{
    '{0, 1, 3, 2, 0, 1},
    '{0, 3, 6, 2, 0, 1},
    '{1, 0, 2, 1, 0, 4},
    '{2, 0, 0, 2, 0, 2},
    '{2, 1, 1, 1, 0, 0},
    '{2, 2, 2, 3, 0, 4},
    '{2, 3, 3, 1, 0, 1},
    '{2, 4, 4, 2, 0, 3},
    '{2, 0, 5, 1, 0, 0},
    '{2, 1, 6, 4, 0, 1},
    '{2, 2, 7, 2, 0, 2},
    '{3, 0, 0, 4, 0, 2},
    '{3, 2, 7, 3, 0, 2},
    '{3, 4, 0, 4, 0, 2},
    '{3, 0, 7, 3, 0, 2},
    '{4, 2, 4, 0, 1, 3},
    '{4, 2, 4, 0, 1, 3},
    '{4, 4, 1, 0, 0, 0}
};

function automatic string test_name(int t);
    case (t)
        0: return "first_contention";
        1: return "single_flit";
        2: return "all_destinations";
        3: return "wormhole_lock";
        4: return "back_pressure";
        default: return "unknown";
    endcase
endfunction

`endif

// ==== tests/router_tb.sv ====
// Testbench for the credit-flow wormhole router.
// Credit-aware drivers send the table's packets, sinks return credits,
// and a scoreboard checks routing, flit order, wormhole locking and credit counts.

`timescale 1ns/100ps

module router_tb import noc_router_pkg::*; ();

    `include "router_cases.svh"

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [FLIT_WIDTH-1:0] data_in     [NUM_PORTS];
    dest_t                 dest_in     [NUM_PORTS];
    logic                  is_tail_in  [NUM_PORTS];
    logic                  send_in     [NUM_PORTS];
    logic                  credit_out  [NUM_PORTS];
    logic [FLIT_WIDTH-1:0] data_out    [NUM_PORTS];
    dest_t                 dest_out    [NUM_PORTS];
    logic                  is_tail_out [NUM_PORTS];
    logic                  send_out    [NUM_PORTS];
    logic                  credit_in   [NUM_PORTS];

    // Sender and sink state
    int pend [NUM_PORTS][$];
    int cur_idx       [NUM_PORTS];
    int tx_credits    [NUM_PORTS] = '{default: BUFFER_DEPTH};
    int owed          [NUM_PORTS];
    int flits_sent    [NUM_PORTS];
    int credit_pulses [NUM_PORTS];
    int credit_cycle  [NUM_PORTS];
    int send_count    [NUM_PORTS];
    int cur_pkt       [NUM_PORTS] = '{default: -1};

    // Per-packet scoreboard
    int lens      [NUM_PKTS];
    int next_idx  [NUM_PKTS];
    int in_cycle  [NUM_PKTS];
    int out_first [NUM_PKTS];
    int out_tail  [NUM_PKTS];

    int          cycle;
    int          limit;
    int          queued_flits;
    int          recv_flits;
    int          hold_out = -1;
    int          hold_until;
    int          held_sends;
    int          checks;
    int          errors;
    int unsigned lcg_state = 72;

    always #5 clk = ~clk;

    noc_router u_noc_router (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_in     (data_in),
        .dest_in     (dest_in),
        .is_tail_in  (is_tail_in),
        .send_in     (send_in),
        .credit_out  (credit_out),
        .data_out    (data_out),
        .dest_out    (dest_out),
        .is_tail_out (is_tail_out),
        .send_out    (send_out),
        .credit_in   (credit_in)
    );

    function automatic int next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) & 32'h7fff);
    endfunction

    // Payload word: input, packet number, flit index, fixed tag
    function automatic logic [31:0] make_word(int src, int pkt, int idx);
        return {8'(src), 8'(pkt), 8'(idx), 8'hA5};
    endfunction

    task automatic check_value(string test, string what, logic [31:0] expected,
                               logic [31:0] actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("ERROR %s: %s expected 0x%0h actual 0x%0h", test, what, expected, actual);
        end
    endtask

    task automatic check_true(bit cond, string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Failure: %s", msg);
        end
    endtask

    function automatic bit drained();
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (pend[i].size() != 0 || tx_credits[i] != BUFFER_DEPTH || owed[i] != 0) begin
                return 1'b0;
            end
        end
        return recv_flits == queued_flits;
    endfunction

    // Scoreboard entry for one flit leaving output o
    task automatic record_flit(int o);
        logic [31:0] word;
        int          p;
        int          idx;
        string       name;
        word = data_out[o];
        p    = int'(word[23:16]);
        if (p >= NUM_PKTS) begin
            check_true(1'b0, $sformatf("output %0d sent a flit of unknown packet %0d", o, p));
            return;
        end
        name = test_name(PKT_TABLE[p][0]);
        idx  = next_idx[p];
        check_value(name, $sformatf("packet %0d output", p), PKT_TABLE[p][5], o);
        check_value(name, $sformatf("packet %0d data", p),
                    make_word(PKT_TABLE[p][1], p, idx), word);
        check_value(name, $sformatf("packet %0d dest", p), PKT_TABLE[p][2], dest_out[o]);
        check_value(name, $sformatf("packet %0d is_tail", p), idx == lens[p] - 1,
                    is_tail_out[o]);
        // No other packet may cut into a packet in flight
        if (cur_pkt[o] >= 0) begin
            check_value(name, $sformatf("output %0d packet in flight", o), cur_pkt[o], p);
        end
        if (idx == 0) begin
            out_first[p] = cycle;
        end
        next_idx[p]++;
        recv_flits++;
        if (is_tail_out[o]) begin
            cur_pkt[o]  = -1;
            out_tail[p] = cycle;
        end else begin
            cur_pkt[o] = p;
        end
    endtask

    // Drivers and credit return, a little after each rising edge
    initial begin : drive_inputs
        int p;
        for (int i = 0; i < NUM_PORTS; i++) begin
            data_in[i]    = '0;
            dest_in[i]    = '0;
            is_tail_in[i] = 1'b0;
            send_in[i]    = 1'b0;
            credit_in[i]  = 1'b0;
        end
        forever begin
            @(posedge clk);
            #1;
            cycle++;
            for (int i = 0; i < NUM_PORTS; i++) begin
                send_in[i] = 1'b0;
                if (pend[i].size() > 0 && tx_credits[i] > 0) begin
                    p             = pend[i][0];
                    data_in[i]    = make_word(i, p, cur_idx[i]);
                    // Later flits carry a wrong destination that must be ignored
                    dest_in[i]    = (cur_idx[i] == 0) ? dest_t'(PKT_TABLE[p][2])
                                                      : ~dest_t'(PKT_TABLE[p][2]);
                    is_tail_in[i] = (cur_idx[i] == lens[p] - 1);
                    send_in[i]    = 1'b1;
                    tx_credits[i]--;
                    flits_sent[i]++;
                    if (cur_idx[i] == 0) begin
                        in_cycle[p] = cycle;
                    end
                    if (is_tail_in[i]) begin
                        void'(pend[i].pop_front());
                        cur_idx[i] = 0;
                    end else begin
                        cur_idx[i]++;
                    end
                end
            end
            for (int o = 0; o < NUM_PORTS; o++) begin
                credit_in[o] = (owed[o] > 0) && !(o == hold_out && cycle < hold_until);
                if (credit_in[o]) begin
                    owed[o]--;
                end
            end
        end
    end

    // Outputs are sampled mid-cycle
    initial begin : sample_outputs
        forever begin
            @(negedge clk);
            if (rst_n) begin
                for (int i = 0; i < NUM_PORTS; i++) begin
                    if (credit_out[i]) begin
                        tx_credits[i]++;
                        credit_pulses[i]++;
                        credit_cycle[i] = cycle;
                        check_true(tx_credits[i] <= BUFFER_DEPTH,
                                   $sformatf("input %0d got back more credits than it used", i));
                    end
                end
                for (int o = 0; o < NUM_PORTS; o++) begin
                    if (send_out[o]) begin
                        owed[o]++;
                        send_count[o]++;
                        if (o == hold_out && cycle < hold_until) begin
                            held_sends++;
                        end
                        record_flit(o);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        wait (limit > 0);
        while (cycle < limit) begin
            @(posedge clk);
        end
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : run_tests
        int total;
        int prev;
        int exp_flits;
        string name;
        rst_n = 1'b0;
        total = 0;
        for (int p = 0; p < NUM_PKTS; p++) begin
            lens[p] = (PKT_TABLE[p][3] != 0) ? PKT_TABLE[p][3] : 1 + next_random() % 4;
            total += lens[p];
        end
        limit = 20 * total + 100;

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < NUM_PORTS; i++) begin
            check_value("reset", $sformatf("input %0d credit_out", i), 0, credit_out[i]);
            check_value("reset", $sformatf("output %0d send_out", i), 0, send_out[i]);
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            name = test_name(t);
            repeat (TEST_TABLE[t][0]) @(posedge clk);
            held_sends = 0;
            for (int p = 0; p < NUM_PKTS; p++) begin
                if (PKT_TABLE[p][0] == t) begin
                    if (PKT_TABLE[p][4] != 0) begin
                        hold_out   = PKT_TABLE[p][5];
                        hold_until = cycle + 1 + HOLD_CYCLES;
                    end
                    pend[PKT_TABLE[p][1]].push_back(p);
                    queued_flits += lens[p];
                end
            end
            @(posedge clk);
            while (!drained()) begin
                @(posedge clk);
            end

            prev = -1;
            for (int p = 0; p < NUM_PKTS; p++) begin
                if (PKT_TABLE[p][0] == t) begin
                    if (TEST_TABLE[t][2] != 0) begin
                        check_value(name, "credit_out latency", 1,
                                    credit_cycle[PKT_TABLE[p][1]] - in_cycle[p]);
                        check_value(name, "send_out latency", 2, out_first[p] - in_cycle[p]);
                    end
                    if (TEST_TABLE[t][1] != 0 && prev >= 0) begin
                        check_true(out_first[p] > out_tail[prev],
                                   $sformatf("%s: packet %0d left before packet %0d was done",
                                             name, p, prev));
                    end
                    prev = p;
                end
            end
            if (hold_out >= 0) begin
                check_true(held_sends <= BUFFER_DEPTH,
                           $sformatf("%s: output %0d sent %0d flits without credits back",
                                     name, hold_out, held_sends));
                hold_out = -1;
            end
        end

        // Credits and sends over the whole run
        for (int i = 0; i < NUM_PORTS; i++) begin
            check_value("credit_accounting", $sformatf("input %0d credit_out pulses", i),
                        flits_sent[i], credit_pulses[i]);
            exp_flits = 0;
            for (int p = 0; p < NUM_PKTS; p++) begin
                if (PKT_TABLE[p][5] == i) begin
                    exp_flits += lens[p];
                end
            end
            check_value("credit_accounting", $sformatf("output %0d send_out pulses", i),
                        exp_flits, send_count[i]);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
